/* common/sap_macros.svh */
`ifndef SAP_MACROS_SVH
`define SAP_MACROS_SVH

// datapath and bus width
`define SAP_DATA_W 8

// RAM address width, operand nibble
`define SAP_ADDR_W 4

// words in RAM
`define SAP_MEM_DEPTH 16

// microsteps per instruction, T0 to T4
`define SAP_STEPS 5

`endif

/* common/sap_pkg.sv */
`default_nettype none

`include "sap_macros.svh"

package sap_pkg;

  typedef logic [`SAP_DATA_W-1:0] data_t;  // bus byte
  typedef logic [`SAP_ADDR_W-1:0] addr_t;  // RAM address

  // upper nibble of the instruction byte, unlisted codes run as NOP
  typedef enum logic [3:0] {
    NOP = 4'd0,
    LDA = 4'd1,
    ADD = 4'd2,
    SUB = 4'd3,
    STA = 4'd4,
    LDI = 4'd5,
    JMP = 4'd6,
    JC  = 4'd7,
    JZ  = 4'd8,
    OUT = 4'd14,
    HLT = 4'd15
  } opcode_e;

  typedef enum logic [2:0] {T0, T1, T2, T3, T4} step_e;

  // one-hot bus driver select
  typedef enum logic [5:0] {
    SRC_NONE = 6'b000001,
    SRC_PC   = 6'b000010,
    SRC_RAM  = 6'b000100,
    SRC_IR   = 6'b001000,
    SRC_A    = 6'b010000,
    SRC_ALU  = 6'b100000
  } bus_src_e;

endpackage

`default_nettype wire

/* controller/sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sap_macros.svh"

module sequencer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              run,
  input  logic              prog_mode,
  input  sap_pkg::data_t    bus,
  input  logic              carry,
  input  logic              zero,
  output sap_pkg::bus_src_e bus_src,
  output sap_pkg::addr_t    pc,
  output sap_pkg::addr_t    ir_operand,
  output logic              mar_load,
  output logic              ram_write,
  output logic              a_load,
  output logic              b_load,
  output logic              out_load,
  output logic              flags_load,
  output logic              sub,
  output logic              halted
);

  sap_pkg::step_e   step;
  sap_pkg::data_t   ir;
  sap_pkg::opcode_e opcode;

  logic active;
  logic ir_load;
  logic pc_load;
  logic pc_inc;
  logic halt_now;

  assign active     = run & ~prog_mode & ~halted;
  assign opcode     = sap_pkg::opcode_e'(ir[`SAP_DATA_W-1:`SAP_ADDR_W]);
  assign ir_operand = ir[`SAP_ADDR_W-1:0];

  // microstep counter, frozen while paused or halted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step <= sap_pkg::T0;
    end else if (active && !halt_now) begin
      if (step == sap_pkg::step_e'(`SAP_STEPS - 1)) begin
        step <= sap_pkg::T0;
      end else begin
        step <= sap_pkg::step_e'(step + 3'd1);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halted <= 1'b0;
    end else if (halt_now) begin
      halted <= 1'b1;  // only reset clears it
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (pc_load) begin
      pc <= bus[`SAP_ADDR_W-1:0];
    end else if (pc_inc) begin
      pc <= pc + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ir <= '0;
    end else if (ir_load) begin
      ir <= bus;
    end
  end

  // control decode from opcode and step
  always_comb begin
    bus_src    = sap_pkg::SRC_NONE;
    mar_load   = 1'b0;
    ram_write  = 1'b0;
    ir_load    = 1'b0;
    pc_load    = 1'b0;
    pc_inc     = 1'b0;
    a_load     = 1'b0;
    b_load     = 1'b0;
    out_load   = 1'b0;
    flags_load = 1'b0;
    sub        = 1'b0;
    halt_now   = 1'b0;
    if (active) begin
      unique case (step)
        sap_pkg::T0: begin  // fetch address
          bus_src  = sap_pkg::SRC_PC;
          mar_load = 1'b1;
        end
        sap_pkg::T1: begin  // fetch instruction
          bus_src = sap_pkg::SRC_RAM;
          ir_load = 1'b1;
          pc_inc  = 1'b1;
        end
        sap_pkg::T2: begin
          case (opcode)
            sap_pkg::LDA, sap_pkg::ADD, sap_pkg::SUB, sap_pkg::STA: begin
              bus_src  = sap_pkg::SRC_IR;
              mar_load = 1'b1;
            end
            sap_pkg::LDI: begin
              bus_src = sap_pkg::SRC_IR;
              a_load  = 1'b1;
            end
            sap_pkg::JMP: begin
              bus_src = sap_pkg::SRC_IR;
              pc_load = 1'b1;
            end
            sap_pkg::JC: begin
              bus_src = carry ? sap_pkg::SRC_IR : sap_pkg::SRC_NONE;
              pc_load = carry;
            end
            sap_pkg::JZ: begin
              bus_src = zero ? sap_pkg::SRC_IR : sap_pkg::SRC_NONE;
              pc_load = zero;
            end
            sap_pkg::OUT: begin
              bus_src  = sap_pkg::SRC_A;
              out_load = 1'b1;
            end
            sap_pkg::HLT: halt_now = 1'b1;
            default: ;  // NOP and unused codes
          endcase
        end
        sap_pkg::T3: begin
          case (opcode)
            sap_pkg::LDA: begin
              bus_src = sap_pkg::SRC_RAM;
              a_load  = 1'b1;
            end
            sap_pkg::ADD, sap_pkg::SUB: begin
              bus_src = sap_pkg::SRC_RAM;
              b_load  = 1'b1;
            end
            sap_pkg::STA: begin
              bus_src   = sap_pkg::SRC_A;
              ram_write = 1'b1;
            end
            default: ;
          endcase
        end
        sap_pkg::T4: begin
          if (opcode == sap_pkg::ADD || opcode == sap_pkg::SUB) begin
            bus_src    = sap_pkg::SRC_ALU;
            a_load     = 1'b1;
            flags_load = 1'b1;
            sub        = (opcode == sap_pkg::SUB);
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* memory/ram_mar.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sap_macros.svh"

module ram_mar (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           prog_mode,
  input  sap_pkg::addr_t dip_addr,
  input  sap_pkg::data_t dip_data,
  input  logic           dip_write,
  input  sap_pkg::data_t bus,
  input  logic           mar_load,
  input  logic           ram_write,
  output sap_pkg::data_t ram_data
);

  sap_pkg::data_t mem [`SAP_MEM_DEPTH];

  sap_pkg::addr_t mar;
  sap_pkg::addr_t rd_addr;

  // run-mode write is delayed one cycle, as on the breadboard
  logic           wr_pend;
  sap_pkg::addr_t wr_addr;
  sap_pkg::data_t wr_data;

  // memory address register takes the low nibble of the bus
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mar <= '0;
    end else if (mar_load) begin
      mar <= bus[`SAP_ADDR_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_pend <= 1'b0;
    end else begin
      wr_pend <= ram_write & ~prog_mode;
    end
  end

  always_ff @(posedge clk) begin
    wr_addr <= mar;
    wr_data <= bus;  // A is on the bus during the strobe
  end

  // switches win when both paths want the port
  always_ff @(posedge clk) begin
    if (prog_mode && dip_write) begin
      mem[dip_addr] <= dip_data;
    end else if (wr_pend) begin
      mem[wr_addr] <= wr_data;
    end
  end

  assign rd_addr  = prog_mode ? dip_addr : mar;  // address mux
  assign ram_data = mem[rd_addr];

endmodule

`default_nettype wire

/* sap_top.f */
+incdir+common
common/sap_pkg.sv
memory/ram_mar.sv
verilog/accumulator_unit.sv
controller/sequencer.sv
verilog/sap_top.sv
verification/sap_clock_gen.sv
verification/sap_tb.sv

/* verification/sap_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module sap_clock_gen #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // power-on reset, released just after a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* verification/sap_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sap_macros.svh"

module sap_tb;

  localparam int N_PROGRAMS = 16;
  localparam int MAX_INSTR  = 80;  // longest countdown loop is about 65
  localparam int CYCLE_NS   = 4;
  localparam int LIMIT_NS   = N_PROGRAMS * (MAX_INSTR * `SAP_STEPS + 150) * CYCLE_NS;
  localparam int DRIVE_DLY  = 1;

  logic           clk;
  logic           por_n;
  logic           tb_rst_n;
  logic           rst_n;
  logic           run;
  logic           prog_mode;
  sap_pkg::addr_t dip_addr;
  sap_pkg::data_t dip_data;
  logic           dip_write;
  sap_pkg::data_t out_value;
  logic           out_valid;
  logic           halted;

  integer         seed;
  int             mismatches;
  int             failures;
  int             pulse_count;
  logic           paused;  // prog_mode has been high for a full cycle
  string          test_name;
  sap_pkg::data_t prog_mem [`SAP_MEM_DEPTH];
  sap_pkg::data_t exp_q [$];

  assign rst_n = por_n & tb_rst_n;

  sap_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(4)) sap_clock_gen_i (
    .clk   (clk),
    .rst_n (por_n)
  );

  sap_top sap_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .prog_mode (prog_mode),
    .dip_addr  (dip_addr),
    .dip_data  (dip_data),
    .dip_write (dip_write),
    .out_value (out_value),
    .out_valid (out_valid),
    .halted    (halted)
  );

  task automatic wait_drive_point();
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  task automatic report_counts();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
  endtask

  // instruction-level model over a copy of RAM fills exp_q
  task automatic interpret_program();
    sap_pkg::data_t mem [`SAP_MEM_DEPTH];
    sap_pkg::data_t ir;
    sap_pkg::data_t a;
    sap_pkg::data_t b;
    sap_pkg::addr_t pc;
    logic           carry;
    logic           zero;
    bit             done;
    int             count;
    mem = prog_mem;
    a = '0;
    pc = '0;
    carry = 1'b0;
    zero = 1'b0;
    done = 1'b0;
    count = 0;
    exp_q.delete();
    while (!done && count < MAX_INSTR) begin
      ir = mem[pc];
      pc = pc + 1'b1;
      count++;
      case (ir[7:4])
        sap_pkg::LDA: a = mem[ir[3:0]];
        sap_pkg::ADD: begin
          b = mem[ir[3:0]];
          carry = (int'(a) + int'(b)) > 255;
          a = a + b;  // wraps at 8 bits
          zero = (a == 0);
        end
        sap_pkg::SUB: begin
          b = mem[ir[3:0]];
          carry = (a >= b);  // no borrow
          a = a - b;
          zero = (a == 0);
        end
        sap_pkg::STA: mem[ir[3:0]] = a;
        sap_pkg::LDI: a = {4'd0, ir[3:0]};
        sap_pkg::JMP: pc = ir[3:0];
        sap_pkg::JC:  if (carry) pc = ir[3:0];
        sap_pkg::JZ:  if (zero) pc = ir[3:0];
        sap_pkg::OUT: exp_q.push_back(a);
        sap_pkg::HLT: done = 1'b1;
        default: ;
      endcase
    end
    if (!done) begin
      failures++;
      $display("ERROR: %s model ran %0d instructions without reaching HLT", test_name, count);
    end
  endtask

  task automatic reset_dut();
    wait_drive_point();
    tb_rst_n = 1'b0;
    repeat (4) begin
      @(negedge clk);
      if (halted !== 1'b0 || out_valid !== 1'b0) begin
        failures++;
        $display("ERROR: %s halted or out_valid not cleared by reset", test_name);
      end
    end
    wait_drive_point();
    tb_rst_n = 1'b1;
  endtask

  task automatic load_program();
    int i;
    prog_mode = 1'b1;
    for (i = 0; i < `SAP_MEM_DEPTH; i++) begin
      dip_addr  = sap_pkg::addr_t'(i);
      dip_data  = prog_mem[i];
      dip_write = 1'b1;
      wait_drive_point();
    end
    dip_write = 1'b0;
    prog_mode = 1'b0;
  endtask

  task automatic start_program(input string name);
    test_name = name;
    wait_drive_point();
    run = 1'b0;
    reset_dut();
    interpret_program();
    load_program();
    run = 1'b1;
  endtask

  task automatic wait_for_outs(input int count);
    int base;
    int cycles;
    base = pulse_count;
    cycles = 0;
    while (pulse_count < base + count && cycles < 200) begin
      @(posedge clk);
      cycles++;
    end
    if (pulse_count < base + count) begin
      failures++;
      $display("ERROR: %s gave fewer than %0d OUT pulses in %0d cycles", test_name, count, cycles);
    end
  endtask

  // wait for HLT and watch that the machine stays put
  task automatic expect_halt();
    int cycles;
    int base;
    bit dropped;
    cycles = 0;
    dropped = 1'b0;
    while (halted !== 1'b1 && cycles < MAX_INSTR * `SAP_STEPS) begin
      @(negedge clk);
      cycles++;
    end
    if (halted !== 1'b1) begin
      failures++;
      $display("ERROR: %s did not halt within %0d cycles", test_name, cycles);
    end else begin
      @(posedge clk);
      if (exp_q.size() != 0) begin
        failures++;
        $display("ERROR: %s halted with %0d OUT values not seen", test_name, exp_q.size());
      end
      base = pulse_count;
      repeat (50) begin
        @(negedge clk);
        if (halted !== 1'b1) dropped = 1'b1;
      end
      @(posedge clk);
      if (dropped) begin
        failures++;
        $display("ERROR: %s halted dropped without a reset", test_name);
      end
      if (pulse_count != base) begin
        failures++;
        $display("ERROR: %s out_valid pulsed %0d times after HLT", test_name, pulse_count - base);
      end
    end
  endtask

  task automatic build_straight();
    int             i;
    int             k;
    sap_pkg::addr_t opnd;
    for (i = 0; i < 9; i++) begin
      k    = $unsigned($random(seed)) % 7;
      opnd = sap_pkg::addr_t'(10 + $unsigned($random(seed)) % 6);  // data area
      case (k)
        0: prog_mem[i] = {sap_pkg::NOP, sap_pkg::addr_t'($random(seed))};
        1: prog_mem[i] = {sap_pkg::LDA, opnd};
        2: prog_mem[i] = {sap_pkg::ADD, opnd};
        3: prog_mem[i] = {sap_pkg::SUB, opnd};
        4: prog_mem[i] = {sap_pkg::LDI, sap_pkg::addr_t'($random(seed))};
        default: prog_mem[i] = {sap_pkg::OUT, sap_pkg::addr_t'($random(seed))};
      endcase
    end
    prog_mem[9] = {sap_pkg::HLT, 4'd0};
    for (i = 10; i < `SAP_MEM_DEPTH; i++) begin
      prog_mem[i] = sap_pkg::data_t'($random(seed));
    end
  endtask

  // STA then LDA of the same word
  task automatic build_store();
    int i;
    for (i = 0; i < `SAP_MEM_DEPTH; i++) begin
      prog_mem[i] = sap_pkg::data_t'($random(seed));  // filler and data
    end
    prog_mem[0] = {sap_pkg::LDA, 4'd13};
    prog_mem[1] = {sap_pkg::ADD, 4'd12};
    prog_mem[2] = {sap_pkg::STA, 4'd15};
    prog_mem[3] = {sap_pkg::LDA, 4'd15};
    prog_mem[4] = {sap_pkg::OUT, 4'd0};
    prog_mem[5] = {sap_pkg::LDI, 4'd0};
    prog_mem[6] = {sap_pkg::LDA, 4'd15};
    prog_mem[7] = {sap_pkg::OUT, 4'd0};
    prog_mem[8] = {sap_pkg::HLT, 4'd0};
  endtask

  // count down from n by step until zero or underflow
  task automatic build_countdown(input int n_min, input int n_span, input int step_max);
    int i;
    for (i = 10; i < 14; i++) begin
      prog_mem[i] = sap_pkg::data_t'($random(seed));
    end
    prog_mem[0]  = {sap_pkg::LDA, 4'd14};
    prog_mem[1]  = {sap_pkg::OUT, 4'd0};
    prog_mem[2]  = {sap_pkg::SUB, 4'd15};
    prog_mem[3]  = {sap_pkg::JZ, 4'd7};
    prog_mem[4]  = {sap_pkg::JC, 4'd1};
    prog_mem[5]  = {sap_pkg::LDI, 4'd15};  // underflow marker
    prog_mem[6]  = {sap_pkg::JMP, 4'd8};
    prog_mem[7]  = {sap_pkg::LDI, 4'd0};
    prog_mem[8]  = {sap_pkg::OUT, 4'd0};
    prog_mem[9]  = {sap_pkg::HLT, 4'd0};
    prog_mem[14] = sap_pkg::data_t'(n_min + $unsigned($random(seed)) % n_span);
    prog_mem[15] = sap_pkg::data_t'(1 + $unsigned($random(seed)) % step_max);
  endtask

  // every OUT pulse against the head of the queue
  always @(negedge clk) begin
    sap_pkg::data_t expected;
    if (out_valid === 1'b1) begin
      pulse_count++;
      if (paused) begin
        failures++;
        $display("ERROR: %s OUT pulse while prog_mode was high", test_name);
      end
      if (exp_q.size() == 0) begin
        failures++;
        $display("ERROR: %s OUT pulse 0x%02h with no value expected", test_name, out_value);
      end else begin
        expected = exp_q.pop_front();
        if (out_value !== expected) begin
          mismatches++;
          $display("MISMATCH %s: expected 0x%02h, actual 0x%02h", test_name, expected, out_value);
        end
      end
    end
  end

  initial begin
    int n;
    seed        = 32'h14bb_b470;
    mismatches  = 0;
    failures    = 0;
    pulse_count = 0;
    paused      = 1'b0;
    test_name   = "power_on";
    tb_rst_n    = 1'b1;
    run         = 1'b0;
    prog_mode   = 1'b0;
    dip_addr    = '0;
    dip_data    = '0;
    dip_write   = 1'b0;
    wait (por_n === 1'b1);

    for (n = 0; n < 8; n++) begin
      build_straight();
      start_program("straight_line");
      expect_halt();
    end
    for (n = 0; n < 2; n++) begin
      build_store();
      start_program("store_reload");
      expect_halt();
    end
    for (n = 0; n < 3; n++) begin
      build_countdown(1, 15, 3);
      start_program("countdown_loop");
      expect_halt();
    end

    // RAM survives a reset mid-run so the whole sequence comes again
    build_countdown(6, 10, 1);
    start_program("reset_restart");
    wait_for_outs(2);
    repeat ($unsigned($random(seed)) % 8) @(posedge clk);
    reset_dut();
    interpret_program();
    expect_halt();

    // prog_mode pauses the run while the read mux wanders
    build_countdown(6, 10, 1);
    start_program("prog_pause");
    wait_for_outs(2);
    repeat ($unsigned($random(seed)) % 5) @(posedge clk);
    wait_drive_point();
    prog_mode = 1'b1;
    wait_drive_point();
    paused = 1'b1;  // a pulse from the last out_load is allowed in the first cycle
    repeat (20) begin
      dip_addr = sap_pkg::addr_t'($random(seed));
      wait_drive_point();
    end
    prog_mode = 1'b0;
    paused    = 1'b0;
    expect_halt();

    report_counts();
    if (mismatches + failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(LIMIT_NS);
    failures++;
    $display("ERROR: watchdog expired after %0d ns, the run did not finish", LIMIT_NS);
    report_counts();
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/accumulator_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sap_macros.svh"

module accumulator_unit (
  input  logic           clk,
  input  logic           rst_n,
  input  sap_pkg::data_t bus,
  input  logic           a_load,
  input  logic           b_load,
  input  logic           out_load,
  input  logic           flags_load,
  input  logic           sub,
  output sap_pkg::data_t a_value,
  output sap_pkg::data_t alu_value,
  output sap_pkg::data_t out_value,
  output logic           out_valid,
  output logic           carry,
  output logic           zero
);

  sap_pkg::data_t a_reg;
  sap_pkg::data_t b_reg;
  sap_pkg::data_t out_reg;
  sap_pkg::data_t b_operand;

  logic [`SAP_DATA_W:0] sum;  // 9 bits, top bit is carry out

  // subtract as A + ~B + 1
  assign b_operand = sub ? ~b_reg : b_reg;
  assign sum       = {1'b0, a_reg} + {1'b0, b_operand} + {{`SAP_DATA_W{1'b0}}, sub};

  assign alu_value = sum[`SAP_DATA_W-1:0];
  assign a_value   = a_reg;
  assign out_value = out_reg;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_reg   <= '0;
      b_reg   <= '0;
      out_reg <= '0;
    end else begin
      if (a_load) begin
        a_reg <= bus;
      end
      if (b_load) begin
        b_reg <= bus;
      end
      if (out_load) begin
        out_reg <= bus;
      end
    end
  end

  // flags only move on ADD and SUB
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      carry <= 1'b0;
      zero  <= 1'b0;
    end else if (flags_load) begin
      carry <= sum[`SAP_DATA_W];
      zero  <= (sum[`SAP_DATA_W-1:0] == '0);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= out_load;  // lines up with the new out_reg
    end
  end

endmodule

`default_nettype wire

/* verilog/sap_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sap_macros.svh"

module sap_top (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           run,
  input  logic           prog_mode,
  input  sap_pkg::addr_t dip_addr,
  input  sap_pkg::data_t dip_data,
  input  logic           dip_write,
  output sap_pkg::data_t out_value,
  output logic           out_valid,
  output logic           halted
);

  localparam int PAD_W = `SAP_DATA_W - `SAP_ADDR_W;  // zero fill for nibble sources

  sap_pkg::data_t    bus;
  sap_pkg::bus_src_e bus_src;
  sap_pkg::addr_t    pc;
  sap_pkg::addr_t    ir_operand;
  sap_pkg::data_t    ram_data;
  sap_pkg::data_t    a_value;
  sap_pkg::data_t    alu_value;

  logic mar_load;
  logic ram_write;
  logic a_load;
  logic b_load;
  logic out_load;
  logic flags_load;
  logic sub;
  logic carry;
  logic zero;

  // single bus, one driver per cycle
  always_comb begin
    case (bus_src)
      sap_pkg::SRC_PC:  bus = {{PAD_W{1'b0}}, pc};
      sap_pkg::SRC_RAM: bus = ram_data;
      sap_pkg::SRC_IR:  bus = {{PAD_W{1'b0}}, ir_operand};
      sap_pkg::SRC_A:   bus = a_value;
      sap_pkg::SRC_ALU: bus = alu_value;
      default:          bus = '0;  // SRC_NONE
    endcase
  end

  ram_mar ram_mar_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_mode (prog_mode),
    .dip_addr  (dip_addr),
    .dip_data  (dip_data),
    .dip_write (dip_write),
    .bus       (bus),
    .mar_load  (mar_load),
    .ram_write (ram_write),
    .ram_data  (ram_data)
  );

  accumulator_unit accumulator_unit_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (bus),
    .a_load     (a_load),
    .b_load     (b_load),
    .out_load   (out_load),
    .flags_load (flags_load),
    .sub        (sub),
    .a_value    (a_value),
    .alu_value  (alu_value),
    .out_value  (out_value),
    .out_valid  (out_valid),
    .carry      (carry),
    .zero       (zero)
  );

  sequencer sequencer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .prog_mode  (prog_mode),
    .bus        (bus),
    .carry      (carry),
    .zero       (zero),
    .bus_src    (bus_src),
    .pc         (pc),
    .ir_operand (ir_operand),
    .mar_load   (mar_load),
    .ram_write  (ram_write),
    .a_load     (a_load),
    .b_load     (b_load),
    .out_load   (out_load),
    .flags_load (flags_load),
    .sub        (sub),
    .halted     (halted)
  );

endmodule

`default_nettype wire
